// File: filelist.f
+incdir+hw
hw/core_pkg.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/lsu_mem.sv
hw/inst_decode.sv
hw/inst_fetch.sv
hw/core_top.sv
testbench/tb_core_top.sv

// File: hw/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath width
`define XLEN 64

// integer register file
`define REG_NUM 32
`define REG_AW 5

// data memory, in doublewords
`define DMEM_WORDS 32
`define DMEM_AW 5

// first fetch address out of reset
`define RESET_PC 64'h0000_0000_8000_0000

`endif

// File: hw/core_pkg.sv
package core_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered, bit 0 is implied
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one fetched word, every format view at once
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_inst_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_WORD,
    MEM_DOUBLE
  } mem_wdth_e;

endpackage

// File: hw/core_top.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_top (
  input  logic                clk,
  input  logic                reset_i,
  // instruction fetch channel
  output logic                inst_arvalid_o,
  output logic [`XLEN-1:0]    inst_araddr_o,
  input  logic                inst_arready_i,
  input  logic                inst_rvalid_i,
  input  logic [31:0]         inst_rdata_i,
  output logic                inst_rready_o,
  // retirement trace
  output logic                retire_valid_o,
  output logic [`XLEN-1:0]    retire_pc_o,
  output logic [`REG_AW-1:0]  retire_rd_o,
  output logic                retire_we_o,
  output logic [`XLEN-1:0]    retire_wdata_o
);

  // fetch -> decode
  logic                commit;
  core_pkg::rv_inst_u  inst;
  logic [`XLEN-1:0]    pc;

  // decode <-> regfile
  logic [`REG_AW-1:0]  raddr1, raddr2;
  logic [`XLEN-1:0]    rdata1, rdata2;

  // decode -> execute / lsu / fetch
  logic [`XLEN-1:0]    op1, op2;
  core_pkg::alu_op_e   alu_op;
  logic [`REG_AW-1:0]  rd;
  logic                reg_we;
  core_pkg::mem_wdth_e mem_wdth;
  logic                load, store;
  logic [`XLEN-1:0]    store_data;
  logic                branch, branch_ne, jump;
  logic [`XLEN-1:0]    target;

  logic [`XLEN-1:0]    alu_result;
  logic                taken;
  logic [`XLEN-1:0]    load_data;

  // write-back select
  logic [`XLEN-1:0]    wb_data;
  logic                rf_we;

  assign wb_data = load ? load_data :
                   jump ? pc + `XLEN'd4 : alu_result;
  assign rf_we   = commit & reg_we;  // x0 filtered inside regfile

  inst_fetch fetch0 (
    .clk            (clk),
    .reset_i        (reset_i),
    .inst_arvalid_o (inst_arvalid_o),
    .inst_araddr_o  (inst_araddr_o),
    .inst_arready_i (inst_arready_i),
    .inst_rvalid_i  (inst_rvalid_i),
    .inst_rdata_i   (inst_rdata_i),
    .inst_rready_o  (inst_rready_o),
    .branch_i       (branch),
    .jump_i         (jump),
    .taken_i        (taken),
    .target_i       (target),
    .rd_i           (rd),
    .reg_we_i       (reg_we),
    .wb_data_i      (wb_data),
    .commit_o       (commit),
    .inst_o         (inst),
    .pc_o           (pc),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_we_o    (retire_we_o),
    .retire_wdata_o (retire_wdata_o)
  );

  inst_decode decode0 (
    .inst_i       (inst),
    .pc_i         (pc),
    .raddr1_o     (raddr1),
    .raddr2_o     (raddr2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .op1_o        (op1),
    .op2_o        (op2),
    .alu_op_o     (alu_op),
    .rd_o         (rd),
    .reg_we_o     (reg_we),
    .mem_wdth_o   (mem_wdth),
    .load_o       (load),
    .store_o      (store),
    .store_data_o (store_data),
    .branch_o     (branch),
    .branch_ne_o  (branch_ne),
    .jump_o       (jump),
    .target_o     (target)
  );

  exec_unit exec0 (
    .op1_i       (op1),
    .op2_i       (op2),
    .alu_op_i    (alu_op),
    .branch_ne_i (branch_ne),
    .result_o    (alu_result),
    .taken_o     (taken)
  );

  lsu_mem lsu0 (
    .clk          (clk),
    .addr_i       (alu_result),  // rs1 + offset
    .mem_wdth_i   (mem_wdth),
    .load_i       (load),
    .store_i      (store),
    .commit_i     (commit),
    .store_data_i (store_data),
    .load_data_o  (load_data)
  );

  reg_file regs0 (
    .clk      (clk),
    .we_i     (rf_we),
    .waddr_i  (rd),
    .wdata_i  (wb_data),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module exec_unit (
  input  logic [`XLEN-1:0]  op1_i,
  input  logic [`XLEN-1:0]  op2_i,
  input  core_pkg::alu_op_e alu_op_i,
  input  logic              branch_ne_i,
  output logic [`XLEN-1:0]  result_o,
  output logic              taken_o
);

  logic [5:0] shamt;
  logic       equal;

  assign shamt = op2_i[5:0];  // rv64 shifts use six bits
  assign equal = (op1_i == op2_i);

  always_comb begin
    case (alu_op_i)
      core_pkg::ALU_ADD:    result_o = op1_i + op2_i;
      core_pkg::ALU_SUB:    result_o = op1_i - op2_i;
      core_pkg::ALU_AND:    result_o = op1_i & op2_i;
      core_pkg::ALU_OR:     result_o = op1_i | op2_i;
      core_pkg::ALU_XOR:    result_o = op1_i ^ op2_i;
      core_pkg::ALU_SLL:    result_o = op1_i << shamt;
      core_pkg::ALU_SRL:    result_o = op1_i >> shamt;
      core_pkg::ALU_SRA:    result_o = $signed(op1_i) >>> shamt;
      core_pkg::ALU_SLT: begin
        result_o = {{(`XLEN-1){1'b0}}, ($signed(op1_i) < $signed(op2_i))};
      end
      core_pkg::ALU_PASS_B: result_o = op2_i;
      default:              result_o = '0;
    endcase
  end

  // only looked at when decode flags a branch
  assign taken_o = branch_ne_i ? ~equal : equal;

endmodule

// File: hw/inst_decode.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module inst_decode (
  input  core_pkg::rv_inst_u  inst_i,
  input  logic [`XLEN-1:0]    pc_i,
  output logic [`REG_AW-1:0]  raddr1_o,
  output logic [`REG_AW-1:0]  raddr2_o,
  input  logic [`XLEN-1:0]    rdata1_i,
  input  logic [`XLEN-1:0]    rdata2_i,
  output logic [`XLEN-1:0]    op1_o,
  output logic [`XLEN-1:0]    op2_o,
  output core_pkg::alu_op_e   alu_op_o,
  output logic [`REG_AW-1:0]  rd_o,
  output logic                reg_we_o,
  output core_pkg::mem_wdth_e mem_wdth_o,
  output logic                load_o,
  output logic                store_o,
  output logic [`XLEN-1:0]    store_data_o,
  output logic                branch_o,
  output logic                branch_ne_o,
  output logic                jump_o,
  output logic [`XLEN-1:0]    target_o
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic             alt;  // funct7 = 0100000, sub / sra

  assign imm_i = {{(`XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
  assign imm_s = {{(`XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
  assign imm_b = {{(`XLEN-13){inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                  inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
  assign imm_u = {{(`XLEN-32){inst_i.u.imm[19]}}, inst_i.u.imm, 12'b0};
  assign imm_j = {{(`XLEN-21){inst_i.j.imm20}}, inst_i.j.imm20, inst_i.j.imm19_12,
                  inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};

  assign alt = (inst_i.r.funct7 == 7'b0100000);

  // register indices sit in the same place for every format
  assign raddr1_o     = inst_i.r.rs1;
  assign raddr2_o     = inst_i.r.rs2;
  assign rd_o         = inst_i.r.rd;
  assign store_data_o = rdata2_i;

  always_comb begin
    op1_o       = rdata1_i;
    op2_o       = rdata2_i;
    alu_op_o    = core_pkg::ALU_ADD;
    reg_we_o    = 1'b0;
    mem_wdth_o  = core_pkg::MEM_NONE;
    load_o      = 1'b0;
    store_o     = 1'b0;
    branch_o    = 1'b0;
    branch_ne_o = 1'b0;
    jump_o      = 1'b0;
    target_o    = pc_i + imm_b;

    case (inst_i.r.opcode)
      OPC_OP: begin
        reg_we_o = 1'b1;
        case (inst_i.r.funct3)
          3'b000: alu_op_o = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
          3'b001: alu_op_o = core_pkg::ALU_SLL;
          3'b010: alu_op_o = core_pkg::ALU_SLT;
          3'b100: alu_op_o = core_pkg::ALU_XOR;
          3'b101: alu_op_o = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
          3'b110: alu_op_o = core_pkg::ALU_OR;
          3'b111: alu_op_o = core_pkg::ALU_AND;
          default: reg_we_o = 1'b0;  // sltu not supported
        endcase
      end
      OPC_OP_IMM: begin
        if (inst_i.i.funct3 == 3'b000) begin  // addi only
          op2_o    = imm_i;
          reg_we_o = 1'b1;
        end
      end
      OPC_LUI: begin
        op2_o    = imm_u;
        alu_op_o = core_pkg::ALU_PASS_B;
        reg_we_o = 1'b1;
      end
      OPC_LOAD: begin
        op2_o = imm_i;
        if (inst_i.i.funct3 == 3'b011 || inst_i.i.funct3 == 3'b010) begin
          reg_we_o   = 1'b1;
          load_o     = 1'b1;
          mem_wdth_o = inst_i.i.funct3[0] ? core_pkg::MEM_DOUBLE : core_pkg::MEM_WORD;
        end
      end
      OPC_STORE: begin
        op2_o = imm_s;
        if (inst_i.s.funct3 == 3'b011 || inst_i.s.funct3 == 3'b010) begin
          store_o    = 1'b1;
          mem_wdth_o = inst_i.s.funct3[0] ? core_pkg::MEM_DOUBLE : core_pkg::MEM_WORD;
        end
      end
      OPC_BRANCH: begin
        // beq / bne compare rs1 against rs2
        branch_o    = (inst_i.b.funct3[2:1] == 2'b00);
        branch_ne_o = inst_i.b.funct3[0];
      end
      OPC_JAL: begin
        reg_we_o = 1'b1;
        jump_o   = 1'b1;
        target_o = pc_i + imm_j;
      end
      default: ;
    endcase
  end

endmodule

// File: hw/inst_fetch.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module inst_fetch (
  input  logic                clk,
  input  logic                reset_i,
  output logic                inst_arvalid_o,
  output logic [`XLEN-1:0]    inst_araddr_o,
  input  logic                inst_arready_i,
  input  logic                inst_rvalid_i,
  input  logic [31:0]         inst_rdata_i,
  output logic                inst_rready_o,
  input  logic                branch_i,
  input  logic                jump_i,
  input  logic                taken_i,
  input  logic [`XLEN-1:0]    target_i,
  input  logic [`REG_AW-1:0]  rd_i,
  input  logic                reg_we_i,
  input  logic [`XLEN-1:0]    wb_data_i,
  output logic                commit_o,
  output core_pkg::rv_inst_u  inst_o,
  output logic [`XLEN-1:0]    pc_o,
  output logic                retire_valid_o,
  output logic [`XLEN-1:0]    retire_pc_o,
  output logic [`REG_AW-1:0]  retire_rd_o,
  output logic                retire_we_o,
  output logic [`XLEN-1:0]    retire_wdata_o
);

  localparam logic [1:0] ST_IDLE = 2'd0;  // one cycle after reset
  localparam logic [1:0] ST_REQ  = 2'd1;  // address phase
  localparam logic [1:0] ST_WAIT = 2'd2;  // waiting for read data

  logic [1:0]       state_q, state_d;
  logic [`XLEN-1:0] pc_q, pc_next;

  assign inst_arvalid_o = (state_q == ST_REQ);
  assign inst_araddr_o  = pc_q;
  assign inst_rready_o  = (state_q == ST_WAIT);
  assign commit_o       = inst_rready_o & inst_rvalid_i;
  assign inst_o         = inst_rdata_i;  // decoded in the same cycle
  assign pc_o           = pc_q;

  always_comb begin
    if (jump_i || (branch_i && taken_i)) begin
      pc_next = target_i;
    end else begin
      pc_next = pc_q + `XLEN'd4;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: state_d = ST_REQ;
      ST_REQ:  if (inst_arready_i) state_d = ST_WAIT;
      ST_WAIT: if (inst_rvalid_i) state_d = ST_REQ;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      pc_q    <= `RESET_PC;
    end else begin
      state_q <= state_d;
      if (commit_o) pc_q <= pc_next;
    end
  end

  // retire trace lags commit by one cycle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= commit_o;
    end
  end

  always_ff @(posedge clk) begin
    if (commit_o) begin
      retire_pc_o    <= pc_q;
      retire_rd_o    <= rd_i;
      retire_we_o    <= reg_we_i;  // x0 writes still report we
      retire_wdata_o <= wb_data_i;
    end
  end

endmodule

// File: hw/lsu_mem.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module lsu_mem (
  input  logic                clk,
  input  logic [`XLEN-1:0]    addr_i,
  input  core_pkg::mem_wdth_e mem_wdth_i,
  input  logic                load_i,
  input  logic                store_i,
  input  logic                commit_i,
  input  logic [`XLEN-1:0]    store_data_i,
  output logic [`XLEN-1:0]    load_data_o
);

  logic [`XLEN-1:0]   mem [`DMEM_WORDS];
  logic [`DMEM_AW-1:0] idx;
  logic               hi_half;
  logic [`XLEN-1:0]   dword;
  logic [31:0]        word;

  // doubleword index wraps over the array
  assign idx     = addr_i[`DMEM_AW+2:3];
  assign hi_half = addr_i[2];
  assign dword   = mem[idx];
  assign word    = hi_half ? dword[63:32] : dword[31:0];

  always_comb begin
    load_data_o = '0;
    if (load_i) begin
      case (mem_wdth_i)
        core_pkg::MEM_WORD:   load_data_o = {{(`XLEN-32){word[31]}}, word};  // lw
        core_pkg::MEM_DOUBLE: load_data_o = dword;
        default:              load_data_o = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (commit_i && store_i) begin
      case (mem_wdth_i)
        core_pkg::MEM_DOUBLE: mem[idx] <= store_data_i;
        core_pkg::MEM_WORD: begin
          // sw keeps the other half intact
          if (hi_half) begin
            mem[idx][63:32] <= store_data_i[31:0];
          end else begin
            mem[idx][31:0] <= store_data_i[31:0];
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module reg_file (
  input  logic               clk,
  input  logic               we_i,
  input  logic [`REG_AW-1:0] waddr_i,
  input  logic [`XLEN-1:0]   wdata_i,
  input  logic [`REG_AW-1:0] raddr1_i,
  input  logic [`REG_AW-1:0] raddr2_i,
  output logic [`XLEN-1:0]   rdata1_o,
  output logic [`XLEN-1:0]   rdata2_o
);

  logic [`XLEN-1:0] regs [`REG_NUM];

  always_ff @(posedge clk) begin
    if (we_i && waddr_i != '0) begin  // x0 is never written
      regs[waddr_i] <= wdata_i;
    end
  end

  // combinational reads, x0 hardwired
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
  --top-module tb_core_top -o tb_core_top

sim_out=$(./obj_dir/tb_core_top || true)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST RESULT: PASS"

// File: testbench/core_cases.txt
# I <fetch address> <instruction word>
# E <retire pc> <rd> <we> <wdata>, one per retirement in program order
I 80000000 00500093
I 80000004 FFD00113
I 80000008 002081B3
I 8000000C 40208233
I 80000010 0020F2B3
I 80000014 0020E333
I 80000018 0020C3B3
I 8000001C 00111433
I 80000020 001154B3
I 80000024 40115533
I 80000028 001125B3
I 8000002C 80000637
I 80000030 00708013
I 80000034 001006B3
I 80000038 04000713
I 8000003C 00873023
I 80000040 00073783
I 80000044 00172223
I 80000048 00073803
I 8000004C 00072883
I 80000050 00472903
I 80000054 00D08463
I 80000058 00100993
I 8000005C 00209463
I 80000060 00200993
I 80000064 00208463
I 80000068 00C00A6F
I 8000006C 00300993
I 80000070 00400993
I 80000074 001A0AB3
I 80000078 0000006F
E 80000000 01 1 0000000000000005
E 80000004 02 1 FFFFFFFFFFFFFFFD
E 80000008 03 1 0000000000000002
E 8000000C 04 1 0000000000000008
E 80000010 05 1 0000000000000005
E 80000014 06 1 FFFFFFFFFFFFFFFD
E 80000018 07 1 FFFFFFFFFFFFFFF8
E 8000001C 08 1 FFFFFFFFFFFFFFA0
E 80000020 09 1 07FFFFFFFFFFFFFF
E 80000024 0A 1 FFFFFFFFFFFFFFFF
E 80000028 0B 1 0000000000000001
E 8000002C 0C 1 FFFFFFFF80000000
E 80000030 00 1 000000000000000C
E 80000034 0D 1 0000000000000005
E 80000038 0E 1 0000000000000040
E 8000003C 00 0 0000000000000000
E 80000040 0F 1 FFFFFFFFFFFFFFA0
E 80000044 00 0 0000000000000000
E 80000048 10 1 00000005FFFFFFA0
E 8000004C 11 1 FFFFFFFFFFFFFFA0
E 80000050 12 1 0000000000000005
E 80000054 00 0 0000000000000000
E 8000005C 00 0 0000000000000000
E 80000064 00 0 0000000000000000
E 80000068 14 1 000000008000006C
E 80000074 15 1 0000000080000071
E 80000078 00 1 000000008000007C

// File: testbench/tb_core_top.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_core_top;

  localparam int TIMEOUT_CYC = 200;

  logic               clk;
  logic               reset_i;
  logic               inst_arvalid_o;
  logic [`XLEN-1:0]   inst_araddr_o;
  logic               inst_arready_i;
  logic               inst_rvalid_i;
  logic [31:0]        inst_rdata_i;
  logic               inst_rready_o;
  logic               retire_valid_o;
  logic [`XLEN-1:0]   retire_pc_o;
  logic [`REG_AW-1:0] retire_rd_o;
  logic               retire_we_o;
  logic [`XLEN-1:0]   retire_wdata_o;

  logic [31:0] prog [logic [63:0]];  // instruction sram image
  logic [63:0] exp_pc [$];
  logic [63:0] exp_rd [$];
  logic [63:0] exp_we [$];
  logic [63:0] exp_wdata [$];

  integer seed;
  logic   first_done;  // first read-data transfer seen

  core_top dut0 (
    .clk            (clk),
    .reset_i        (reset_i),
    .inst_arvalid_o (inst_arvalid_o),
    .inst_araddr_o  (inst_araddr_o),
    .inst_arready_i (inst_arready_i),
    .inst_rvalid_i  (inst_rvalid_i),
    .inst_rdata_i   (inst_rdata_i),
    .inst_rready_o  (inst_rready_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_we_o    (retire_we_o),
    .retire_wdata_o (retire_wdata_o)
  );

  always #2 clk = ~clk;

  // outputs are settled half a ns after the edge and inputs change there
  task automatic step;
    @(posedge clk);
    #0.5;
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      fail_now($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic load_cases;
    integer      fd;
    integer      n;
    integer      ch;
    logic [7:0]  tag;
    logic [63:0] a, b, c, d;
    fd = $fopen("testbench/core_cases.txt", "r");
    if (fd == 0) fail_now("cannot open testbench/core_cases.txt");
    n = $fscanf(fd, " %c", tag);
    while (n == 1) begin
      if (tag == "I") begin
        n = $fscanf(fd, "%h %h", a, b);
        if (n != 2) fail_now("malformed program line in the cases file");
        prog[a] = b[31:0];
      end else if (tag == "E") begin
        n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
        if (n != 4) fail_now("malformed expected line in the cases file");
        exp_pc.push_back(a);
        exp_rd.push_back(b);
        exp_we.push_back(c);
        exp_wdata.push_back(d);
      end else begin
        ch = $fgetc(fd);  // skip the rest of a comment line
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end
      n = $fscanf(fd, " %c", tag);
    end
    $fclose(fd);
  endtask

  // nothing may retire before the first instruction arrives
  task automatic fetch_step;
    step();
    if (!first_done) check_val("early_retire", 64'd0, 64'(retire_valid_o));
  endtask

  // one request/response pair of the instruction sram
  task automatic serve_fetch;
    int          cnt;
    int          dly;
    logic [63:0] addr;
    cnt = 0;
    while (!inst_arvalid_o) begin
      fetch_step();
      cnt++;
      if (cnt > TIMEOUT_CYC) fail_now("no fetch request within 200 cycles");
    end
    addr = inst_araddr_o;
    if (!first_done) check_val("first_fetch_addr", `RESET_PC, addr);
    check_val("rready_before_addr", 64'd0, 64'(inst_rready_o));
    dly = $unsigned($random(seed)) % 4;
    repeat (dly) begin
      fetch_step();
      check_val("arvalid_held", 64'd1, 64'(inst_arvalid_o));
      check_val("araddr_held", addr, inst_araddr_o);
      check_val("rready_early", 64'd0, 64'(inst_rready_o));
    end
    inst_arready_i = 1'b1;
    fetch_step();  // address transfer on this edge
    inst_arready_i = 1'b0;
    if (!prog.exists(addr)) begin
      fail_now($sformatf("fetch from address %h which holds no instruction", addr));
    end
    cnt = 0;
    while (!inst_rready_o) begin
      fetch_step();
      cnt++;
      if (cnt > TIMEOUT_CYC) fail_now("read-data ready not raised within 200 cycles");
    end
    dly = $unsigned($random(seed)) % 4;
    repeat (dly) begin
      fetch_step();
      check_val("rready_held", 64'd1, 64'(inst_rready_o));
    end
    inst_rvalid_i = 1'b1;
    inst_rdata_i  = prog[addr];
    step();  // commit edge
    inst_rvalid_i = 1'b0;
    inst_rdata_i  = 32'h0;
    first_done    = 1'b1;
  endtask

  task automatic wait_retire(input int idx);
    int cnt;
    cnt = 0;
    while (!retire_valid_o) begin
      step();
      cnt++;
      if (cnt > TIMEOUT_CYC) begin
        fail_now($sformatf("retirement %0d did not arrive within 200 cycles", idx));
      end
    end
  endtask

  initial begin
    int i;
    clk            = 1'b0;
    reset_i        = 1'b1;
    inst_arready_i = 1'b0;
    inst_rvalid_i  = 1'b0;
    inst_rdata_i   = 32'h0;
    seed           = 32'h54c9_e154;
    first_done     = 1'b0;
    load_cases();
    if (exp_pc.size() == 0) fail_now("no expected retirements in the cases file");

    repeat (3) begin
      step();
      check_val("arvalid_in_reset", 64'd0, 64'(inst_arvalid_o));
      check_val("rready_in_reset", 64'd0, 64'(inst_rready_o));
      check_val("retire_in_reset", 64'd0, 64'(retire_valid_o));
    end
    reset_i = 1'b0;

    fork
      forever serve_fetch();
    join_none

    for (i = 0; i < exp_pc.size(); i++) begin
      wait_retire(i);
      check_val($sformatf("retire%0d_pc", i), exp_pc[i], retire_pc_o);
      check_val($sformatf("retire%0d_we", i), exp_we[i], 64'(retire_we_o));
      if (exp_we[i] != 64'd0) begin  // rd and wdata only mean something on a write
        check_val($sformatf("retire%0d_rd", i), exp_rd[i], 64'(retire_rd_o));
        check_val($sformatf("retire%0d_wdata", i), exp_wdata[i], retire_wdata_o);
      end
      step();
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
